// File: common/robot_pkg.sv
package robot_pkg;

    localparam int PWM_PERIOD = 16;
    localparam int PWM_W      = $clog2(PWM_PERIOD);
    localparam int DUTY_STEP  = 4;
    localparam int DUTY_W     = PWM_W + 1;  // duty reaches the full period.
    localparam int DIST_W     = 8;

    localparam logic [PWM_W-1:0]  PWM_LAST    = PWM_W'(PWM_PERIOD - 1);
    localparam logic [DUTY_W-1:0] DUTY_UNIT   = DUTY_W'(DUTY_STEP);
    localparam logic [DIST_W-1:0] E_STOP_DIST = 8'd20;

    // remote key codes.
    localparam logic [7:0] CODE_CAM     = 8'h0f;
    localparam logic [7:0] CODE_IR      = 8'h13;
    localparam logic [7:0] CODE_IDLE    = 8'h10;
    localparam logic [7:0] CODE_FWD     = 8'h05;
    localparam logic [7:0] CODE_LEFT    = 8'h07;
    localparam logic [7:0] CODE_RIGHT   = 8'h09;
    localparam logic [7:0] CODE_ARC_L   = 8'h04;
    localparam logic [7:0] CODE_ARC_R   = 8'h06;
    localparam logic [7:0] CODE_STOP    = 8'h08;
    localparam logic [7:0] CODE_GEAR_UP = 8'h1a;
    localparam logic [7:0] CODE_GEAR_DN = 8'h1e;

    typedef enum logic [1:0] {IDLE = 2'd0, CAM = 2'd1, IR = 2'd2} drive_mode_e;

    typedef enum logic [1:0] {SEARCH = 2'd0, FOLLOW = 2'd1, PAUSE = 2'd3} cam_state_e;

    typedef enum logic [2:0] {
        STOP, FORWARD, LEFT, RIGHT, ARC_LEFT, ARC_RIGHT
    } drive_cmd_e;

    typedef enum logic [3:0] {
        KEY_NONE, KEY_CAM, KEY_IR, KEY_IDLE, KEY_FWD, KEY_LEFT,
        KEY_RIGHT, KEY_ARC_L, KEY_ARC_R, KEY_STOP, KEY_GEAR_UP, KEY_GEAR_DN
    } key_op_e;

    typedef enum logic [2:0] {
        DIR_NONE = 3'd0, DIR_LEFT = 3'd1, DIR_RIGHT = 3'd2, DIR_AHEAD = 3'd3
    } cam_dir_e;

    typedef struct packed {
        logic       orange;
        cam_dir_e   dir;
        logic [1:0] speed;  // 0 slow, 1 medium, 2 fast.
    } cam_in_t;

    typedef struct packed {
        drive_cmd_e cmd;
        logic       gear_up;
        logic       gear_dn;
        logic [1:0] cam_gear;
        logic       cam_active;
    } drive_req_t;

    typedef struct packed {
        logic en_l;
        logic dir_l;  // 1 is forward.
        logic en_r;
        logic dir_r;
    } motor_out_t;

    typedef struct packed {
        drive_mode_e mode;
        drive_cmd_e  cmd;
        logic [1:0]  gear;
    } status_t;

endpackage

// File: design/drive_mode_fsm.sv
`timescale 1ns/1ns

module drive_mode_fsm (
    input  logic                         CLOCK_50,
    input  logic                         rst_n,
    input  logic                         key_valid,
    input  logic [7:0]                   key_code,
    input  robot_pkg::cam_in_t           cam,
    input  logic [robot_pkg::DIST_W-1:0] distance,
    output robot_pkg::drive_req_t        req,
    output robot_pkg::drive_mode_e       mode
);

    robot_pkg::key_op_e     key_op;
    robot_pkg::drive_mode_e mode_next;
    robot_pkg::cam_state_e  cam_state;
    robot_pkg::cam_state_e  cam_state_next;
    robot_pkg::drive_cmd_e  ir_cmd;
    robot_pkg::drive_cmd_e  ir_cmd_next;
    robot_pkg::drive_cmd_e  cmd_next;
    logic [1:0]             cam_gear_next;
    logic                   e_stop;

    always_comb begin
        key_op = robot_pkg::KEY_NONE;
        if (key_valid) begin
            case (key_code)
                robot_pkg::CODE_CAM:     key_op = robot_pkg::KEY_CAM;
                robot_pkg::CODE_IR:      key_op = robot_pkg::KEY_IR;
                robot_pkg::CODE_IDLE:    key_op = robot_pkg::KEY_IDLE;
                robot_pkg::CODE_FWD:     key_op = robot_pkg::KEY_FWD;
                robot_pkg::CODE_LEFT:    key_op = robot_pkg::KEY_LEFT;
                robot_pkg::CODE_RIGHT:   key_op = robot_pkg::KEY_RIGHT;
                robot_pkg::CODE_ARC_L:   key_op = robot_pkg::KEY_ARC_L;
                robot_pkg::CODE_ARC_R:   key_op = robot_pkg::KEY_ARC_R;
                robot_pkg::CODE_STOP:    key_op = robot_pkg::KEY_STOP;
                robot_pkg::CODE_GEAR_UP: key_op = robot_pkg::KEY_GEAR_UP;
                robot_pkg::CODE_GEAR_DN: key_op = robot_pkg::KEY_GEAR_DN;
                default:                 key_op = robot_pkg::KEY_NONE;
            endcase
        end
    end

    assign e_stop = (mode == robot_pkg::IR) && (distance < robot_pkg::E_STOP_DIST);

    always_comb begin
        case (mode)
            robot_pkg::IDLE:
                mode_next = (key_op == robot_pkg::KEY_CAM) ? robot_pkg::CAM :
                            (key_op == robot_pkg::KEY_IR)  ? robot_pkg::IR  : robot_pkg::IDLE;
            robot_pkg::CAM:
                mode_next = (key_op == robot_pkg::KEY_IR)   ? robot_pkg::IR   :
                            (key_op == robot_pkg::KEY_IDLE) ? robot_pkg::IDLE : robot_pkg::CAM;
            robot_pkg::IR:
                mode_next = e_stop                          ? robot_pkg::IDLE :  // beats keys.
                            (key_op == robot_pkg::KEY_CAM)  ? robot_pkg::CAM  :
                            (key_op == robot_pkg::KEY_IDLE) ? robot_pkg::IDLE : robot_pkg::IR;
            default:
                mode_next = robot_pkg::IDLE;
        endcase
    end

    always_comb begin
        if (mode_next != robot_pkg::CAM) begin
            cam_state_next = robot_pkg::PAUSE;
        end else if (mode != robot_pkg::CAM) begin
            cam_state_next = robot_pkg::SEARCH;
        end else begin
            case (cam_state)
                robot_pkg::SEARCH:
                    cam_state_next = cam.orange ? robot_pkg::FOLLOW : robot_pkg::SEARCH;
                robot_pkg::FOLLOW:
                    cam_state_next = cam.orange ? robot_pkg::FOLLOW : robot_pkg::SEARCH;
                default:
                    cam_state_next = robot_pkg::SEARCH;
            endcase
        end
    end

    // remote command holds until the next direction key.
    always_comb begin
        ir_cmd_next = ir_cmd;
        if (mode_next != robot_pkg::IR) begin
            ir_cmd_next = robot_pkg::STOP;
        end else begin
            case (key_op)
                robot_pkg::KEY_FWD:   ir_cmd_next = robot_pkg::FORWARD;
                robot_pkg::KEY_LEFT:  ir_cmd_next = robot_pkg::LEFT;
                robot_pkg::KEY_RIGHT: ir_cmd_next = robot_pkg::RIGHT;
                robot_pkg::KEY_ARC_L: ir_cmd_next = robot_pkg::ARC_LEFT;
                robot_pkg::KEY_ARC_R: ir_cmd_next = robot_pkg::ARC_RIGHT;
                robot_pkg::KEY_STOP:  ir_cmd_next = robot_pkg::STOP;
                default:              ir_cmd_next = ir_cmd;
            endcase
        end
    end

    always_comb begin
        cmd_next      = robot_pkg::STOP;
        cam_gear_next = 2'd0;  // turns run in first gear.
        case (mode_next)
            robot_pkg::CAM: begin
                if (cam_state_next == robot_pkg::FOLLOW) begin
                    case (cam.dir)
                        robot_pkg::DIR_LEFT:  cmd_next = robot_pkg::LEFT;
                        robot_pkg::DIR_RIGHT: cmd_next = robot_pkg::RIGHT;
                        robot_pkg::DIR_AHEAD: begin
                            cmd_next      = robot_pkg::FORWARD;
                            cam_gear_next = cam.speed;
                        end
                        default:              cmd_next = robot_pkg::STOP;
                    endcase
                end else begin
                    cmd_next = robot_pkg::RIGHT;  // spin in place to search.
                end
            end
            robot_pkg::IR: cmd_next = ir_cmd_next;
            default:       cmd_next = robot_pkg::STOP;
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            mode           <= robot_pkg::IDLE;
            cam_state      <= robot_pkg::PAUSE;
            ir_cmd         <= robot_pkg::STOP;
            req.cmd        <= robot_pkg::STOP;
            req.gear_up    <= 1'b0;
            req.gear_dn    <= 1'b0;
            req.cam_gear   <= 2'd0;
            req.cam_active <= 1'b0;
        end else begin
            mode           <= mode_next;
            cam_state      <= cam_state_next;
            ir_cmd         <= ir_cmd_next;
            req.cmd        <= cmd_next;
            req.gear_up    <= (key_op == robot_pkg::KEY_GEAR_UP);
            req.gear_dn    <= (key_op == robot_pkg::KEY_GEAR_DN);
            req.cam_gear   <= cam_gear_next;
            req.cam_active <= (mode_next == robot_pkg::CAM);
        end
    end

    mode_legal_a: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        mode inside {robot_pkg::IDLE, robot_pkg::CAM, robot_pkg::IR})
        else $error("mode out of range: %0d", mode);

    e_stop_a: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        e_stop |=> (mode == robot_pkg::IDLE))
        else $error("obstacle in remote mode did not stop the car");

endmodule

// File: design/pwm_timer.sv
`timescale 1ns/1ns

module pwm_timer (
    input  logic                        CLOCK_50,
    input  logic                        rst_n,
    output logic [robot_pkg::PWM_W-1:0] pwm_count,
    output logic                        period_start
);

    // free-running, wraps after the last count of a period.
    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            pwm_count <= '0;
        end else if (pwm_count == robot_pkg::PWM_LAST) begin
            pwm_count <= '0;
        end else begin
            pwm_count <= pwm_count + 1'b1;
        end
    end

    assign period_start = (pwm_count == '0);  // first count of a period.

endmodule

// File: motor/motor_drive.sv
`timescale 1ns/1ns

module motor_drive (
    input  logic                        CLOCK_50,
    input  logic                        rst_n,
    input  robot_pkg::drive_req_t       req,
    input  logic [robot_pkg::PWM_W-1:0] pwm_count,
    input  logic                        period_start,
    output robot_pkg::motor_out_t       motors,
    output logic [1:0]                  gear
);

    typedef struct packed {
        logic [robot_pkg::DUTY_W-1:0] duty;
        logic                         fwd;
    } wheel_t;

    logic [1:0]                   gear_next;
    logic [1:0]                   gear_eff;
    logic [robot_pkg::DUTY_W-1:0] gear_ext;
    logic [robot_pkg::DUTY_W-1:0] duty_full;
    logic [robot_pkg::DUTY_W-1:0] duty_half;
    wheel_t                       left_next;
    wheel_t                       right_next;
    wheel_t                       left_pend;   // one cycle behind req.
    wheel_t                       right_pend;
    wheel_t                       left_act;    // in force for this period.
    wheel_t                       right_act;
    wheel_t                       left_sel;
    wheel_t                       right_sel;

    always_comb begin
        gear_next = gear;
        if (req.gear_up && gear != 2'd3) begin
            gear_next = gear + 2'd1;
        end else if (req.gear_dn && gear != 2'd0) begin
            gear_next = gear - 2'd1;
        end
    end

    assign gear_eff  = req.cam_active ? req.cam_gear : gear_next;
    assign gear_ext  = {{(robot_pkg::DUTY_W - 2){1'b0}}, gear_eff};
    assign duty_full = robot_pkg::DUTY_UNIT * (gear_ext + 1'b1);
    assign duty_half = duty_full >> 1;

    always_comb begin
        left_next  = '{duty: duty_full, fwd: 1'b1};
        right_next = '{duty: duty_full, fwd: 1'b1};
        case (req.cmd)
            robot_pkg::FORWARD:   left_next.fwd   = 1'b1;
            robot_pkg::LEFT:      left_next.fwd   = 1'b0;  // left wheel backs up.
            robot_pkg::RIGHT:     right_next.fwd  = 1'b0;
            robot_pkg::ARC_LEFT:  left_next.duty  = duty_half;
            robot_pkg::ARC_RIGHT: right_next.duty = duty_half;
            default: begin
                left_next.duty  = '0;
                right_next.duty = '0;
            end
        endcase
    end

    // new values take over only at the start of a period.
    assign left_sel  = period_start ? left_pend : left_act;
    assign right_sel = period_start ? right_pend : right_act;

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            gear       <= 2'd0;
            left_pend  <= '{duty: '0, fwd: 1'b1};
            right_pend <= '{duty: '0, fwd: 1'b1};
            left_act   <= '{duty: '0, fwd: 1'b1};
            right_act  <= '{duty: '0, fwd: 1'b1};
            motors     <= '{en_l: 1'b0, dir_l: 1'b1, en_r: 1'b0, dir_r: 1'b1};
        end else begin
            gear         <= gear_next;
            left_pend    <= left_next;
            right_pend   <= right_next;
            left_act     <= left_sel;
            right_act    <= right_sel;
            motors.en_l  <= ({1'b0, pwm_count} < left_sel.duty);
            motors.dir_l <= left_sel.fwd;
            motors.en_r  <= ({1'b0, pwm_count} < right_sel.duty);
            motors.dir_r <= right_sel.fwd;
        end
    end

    gear_sat_a: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        ((req.gear_up && gear == 2'd3) || (req.gear_dn && gear == 2'd0)) |=> $stable(gear))
        else $error("gear wrapped past its limit: %0d", gear);

endmodule

// File: design/robot_car_top.sv
`timescale 1ns/1ns

module robot_car_top (
    input  logic                         CLOCK_50,
    input  logic                         rst_n,
    input  logic                         key_valid,
    input  logic [7:0]                   key_code,
    input  robot_pkg::cam_in_t           cam,
    input  logic [robot_pkg::DIST_W-1:0] distance,
    output robot_pkg::motor_out_t        motors,
    output robot_pkg::status_t           status
);

    robot_pkg::drive_req_t       req;
    robot_pkg::drive_mode_e      mode;
    logic [robot_pkg::PWM_W-1:0] pwm_count;
    logic                        period_start;
    logic [1:0]                  gear;

    drive_mode_fsm fsm_i (
        .CLOCK_50  (CLOCK_50),
        .rst_n     (rst_n),
        .key_valid (key_valid),
        .key_code  (key_code),
        .cam       (cam),
        .distance  (distance),
        .req       (req),
        .mode      (mode)
    );

    pwm_timer timer_i (
        .CLOCK_50     (CLOCK_50),
        .rst_n        (rst_n),
        .pwm_count    (pwm_count),
        .period_start (period_start)
    );

    motor_drive motor_i (
        .CLOCK_50     (CLOCK_50),
        .rst_n        (rst_n),
        .req          (req),
        .pwm_count    (pwm_count),
        .period_start (period_start),
        .motors       (motors),
        .gear         (gear)
    );

    assign status = '{mode: mode, cmd: req.cmd, gear: gear};

endmodule

// File: verification/robot_car_tb.sv
`timescale 1ns/1ns

module robot_car_tb;

    localparam int TIMEOUT_CYCLES = 6 * 40 * robot_pkg::PWM_PERIOD + 256;

    logic                         CLOCK_50;
    logic                         rst_n;
    logic                         key_valid;
    logic [7:0]                   key_code;
    robot_pkg::cam_in_t           cam;
    logic [robot_pkg::DIST_W-1:0] distance;
    robot_pkg::motor_out_t        motors;
    robot_pkg::status_t           status;

    logic [robot_pkg::PWM_W-1:0]  pwm_phase;  // mirrors the DUT period count.
    int                           cycles = 0;
    int                           errors = 0;
    int                           checks = 0;
    int                           gear_model = 0;

    logic                         chk_status = 1'b0;
    logic                         chk_duty = 1'b0;
    logic                         chk_dir = 1'b0;
    robot_pkg::drive_mode_e       exp_mode;
    robot_pkg::drive_cmd_e        exp_cmd;
    logic [1:0]                   exp_gear;
    int                           exp_on_l;
    int                           exp_on_r;
    int                           meas_on_l;
    int                           meas_on_r;
    logic                         exp_dir_l;
    logic                         exp_dir_r;

    robot_car_top dut_i (
        .CLOCK_50  (CLOCK_50),
        .rst_n     (rst_n),
        .key_valid (key_valid),
        .key_code  (key_code),
        .cam       (cam),
        .distance  (distance),
        .motors    (motors),
        .status    (status)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #2 CLOCK_50 = ~CLOCK_50;
    end

    always @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            pwm_phase <= '0;
        end else begin
            pwm_phase <= pwm_phase + 1'b1;  // wraps with the period.
        end
    end

    always @(posedge CLOCK_50) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    mode_chk_a: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        chk_status |-> status.mode == exp_mode)
        else begin
            errors = errors + 1;
            $display("FAILED t=%0t status.mode expected %0d got %0d", $time, exp_mode,
                     $sampled(status.mode));
        end

    cmd_chk_a: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        chk_status |-> status.cmd == exp_cmd)
        else begin
            errors = errors + 1;
            $display("FAILED t=%0t status.cmd expected %0d got %0d", $time, exp_cmd,
                     $sampled(status.cmd));
        end

    gear_chk_a: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        chk_status |-> status.gear == exp_gear)
        else begin
            errors = errors + 1;
            $display("FAILED t=%0t status.gear expected %0d got %0d", $time, exp_gear,
                     $sampled(status.gear));
        end

    duty_l_chk_a: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        chk_duty |-> meas_on_l == exp_on_l)
        else begin
            errors = errors + 1;
            $display("FAILED t=%0t motors.en_l high cycles expected %0d got %0d", $time,
                     exp_on_l, meas_on_l);
        end

    duty_r_chk_a: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        chk_duty |-> meas_on_r == exp_on_r)
        else begin
            errors = errors + 1;
            $display("FAILED t=%0t motors.en_r high cycles expected %0d got %0d", $time,
                     exp_on_r, meas_on_r);
        end

    dir_l_chk_a: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        chk_dir |-> motors.dir_l == exp_dir_l)
        else begin
            errors = errors + 1;
            $display("FAILED t=%0t motors.dir_l expected %0b got %0b", $time, exp_dir_l,
                     $sampled(motors.dir_l));
        end

    dir_r_chk_a: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        chk_dir |-> motors.dir_r == exp_dir_r)
        else begin
            errors = errors + 1;
            $display("FAILED t=%0t motors.dir_r expected %0b got %0b", $time, exp_dir_r,
                     $sampled(motors.dir_r));
        end

    function automatic int wheel_duty(robot_pkg::drive_cmd_e cmd, int g, bit left);
        int d;
        d = robot_pkg::DUTY_STEP * (g + 1);
        case (cmd)
            robot_pkg::STOP:      return 0;
            robot_pkg::ARC_LEFT:  return left ? d / 2 : d;
            robot_pkg::ARC_RIGHT: return left ? d : d / 2;
            default:              return d;
        endcase
    endfunction

    function automatic logic wheel_fwd(robot_pkg::drive_cmd_e cmd, bit left);
        if (cmd == robot_pkg::LEFT) begin
            return !left;
        end
        if (cmd == robot_pkg::RIGHT) begin
            return left;
        end
        return 1'b1;
    endfunction

    function automatic bit is_known_code(logic [7:0] code);
        return code inside {8'h0f, 8'h13, 8'h10, 8'h05, 8'h07, 8'h09, 8'h04, 8'h06,
                            8'h08, 8'h1a, 8'h1e};
    endfunction

    task automatic send_key(input logic [7:0] code);
        key_valid = 1'b1;
        key_code  = code;
        @(negedge CLOCK_50);
        key_valid = 1'b0;
        key_code  = 8'h00;
    endtask

    task automatic set_cam(input logic o, input robot_pkg::cam_dir_e d, input logic [1:0] s);
        cam = '{orange: o, dir: d, speed: s};
        @(negedge CLOCK_50);
    endtask

    task automatic check_status(input robot_pkg::drive_mode_e m,
                                input robot_pkg::drive_cmd_e c);
        exp_mode   = m;
        exp_cmd    = c;
        exp_gear   = 2'(gear_model);
        chk_status = 1'b1;
        checks     = checks + 3;
        @(negedge CLOCK_50);
        chk_status = 1'b0;
    endtask

    // counts enable-high cycles over one whole period.
    task automatic measure_period(input robot_pkg::drive_cmd_e cmd, input int g);
        int on_l;
        int on_r;
        on_l = 0;
        on_r = 0;
        repeat (3) @(negedge CLOCK_50);
        while (pwm_phase != 1) @(negedge CLOCK_50);
        repeat (robot_pkg::PWM_PERIOD) begin
            if (motors.en_l) on_l++;
            if (motors.en_r) on_r++;
            @(negedge CLOCK_50);
        end
        meas_on_l = on_l;
        meas_on_r = on_r;
        exp_on_l  = wheel_duty(cmd, g, 1'b1);
        exp_on_r  = wheel_duty(cmd, g, 1'b0);
        exp_dir_l = wheel_fwd(cmd, 1'b1);
        exp_dir_r = wheel_fwd(cmd, 1'b0);
        chk_duty  = 1'b1;
        chk_dir   = (cmd != robot_pkg::STOP);
        checks    = checks + ((cmd != robot_pkg::STOP) ? 4 : 2);
        @(negedge CLOCK_50);
        chk_duty  = 1'b0;
        chk_dir   = 1'b0;
    endtask

    task automatic remote_step(input logic [7:0] code, input robot_pkg::drive_cmd_e cmd);
        send_key(code);
        check_status(robot_pkg::IR, cmd);
        measure_period(cmd, gear_model);
    endtask

    task automatic shift_gear(input bit up);
        send_key(up ? robot_pkg::CODE_GEAR_UP : robot_pkg::CODE_GEAR_DN);
        if (up && gear_model < 3) gear_model++;
        if (!up && gear_model > 0) gear_model--;
        @(negedge CLOCK_50);  // gear lands one edge after the request.
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("test %s done, %0d failed checks", name, errors - err_before);
    endtask

    task automatic reset_state_test();
        int err_before;
        err_before = errors;
        check_status(robot_pkg::IDLE, robot_pkg::STOP);
        measure_period(robot_pkg::STOP, 0);
        report_test("reset_state", err_before);
    endtask

    task automatic mode_key_test();
        int         err_before;
        logic [7:0] code;
        err_before = errors;
        send_key(robot_pkg::CODE_CAM);
        check_status(robot_pkg::CAM, robot_pkg::RIGHT);  // search spins.
        send_key(robot_pkg::CODE_IDLE);
        check_status(robot_pkg::IDLE, robot_pkg::STOP);
        send_key(robot_pkg::CODE_IR);
        check_status(robot_pkg::IR, robot_pkg::STOP);
        send_key(robot_pkg::CODE_CAM);
        check_status(robot_pkg::CAM, robot_pkg::RIGHT);
        send_key(robot_pkg::CODE_IR);
        check_status(robot_pkg::IR, robot_pkg::STOP);
        send_key(robot_pkg::CODE_IDLE);
        check_status(robot_pkg::IDLE, robot_pkg::STOP);
        repeat (6) begin
            code = 8'($urandom);
            while (is_known_code(code)) code = 8'($urandom);
            send_key(code);
            check_status(robot_pkg::IDLE, robot_pkg::STOP);
        end
        key_code = robot_pkg::CODE_CAM;  // no strobe.
        @(negedge CLOCK_50);
        key_code = robot_pkg::CODE_IR;
        @(negedge CLOCK_50);
        key_code = 8'h00;
        check_status(robot_pkg::IDLE, robot_pkg::STOP);
        report_test("mode_keys", err_before);
    endtask

    task automatic remote_cmd_test();
        int err_before;
        err_before = errors;
        send_key(robot_pkg::CODE_IR);
        check_status(robot_pkg::IR, robot_pkg::STOP);
        remote_step(robot_pkg::CODE_FWD, robot_pkg::FORWARD);
        remote_step(robot_pkg::CODE_LEFT, robot_pkg::LEFT);
        remote_step(robot_pkg::CODE_RIGHT, robot_pkg::RIGHT);
        remote_step(robot_pkg::CODE_ARC_L, robot_pkg::ARC_LEFT);
        remote_step(robot_pkg::CODE_ARC_R, robot_pkg::ARC_RIGHT);
        remote_step(robot_pkg::CODE_STOP, robot_pkg::STOP);
        report_test("remote_commands", err_before);
    endtask

    task automatic gear_test();
        int err_before;
        err_before = errors;
        send_key(robot_pkg::CODE_FWD);
        check_status(robot_pkg::IR, robot_pkg::FORWARD);
        repeat (4) begin
            shift_gear(1'b1);
            check_status(robot_pkg::IR, robot_pkg::FORWARD);
            measure_period(robot_pkg::FORWARD, gear_model);
        end
        repeat (4) begin
            shift_gear(1'b0);
            check_status(robot_pkg::IR, robot_pkg::FORWARD);
            measure_period(robot_pkg::FORWARD, gear_model);
        end
        report_test("gears", err_before);
    endtask

    task automatic camera_test();
        int err_before;
        err_before = errors;
        shift_gear(1'b1);
        shift_gear(1'b1);  // gear register differs from the camera speed.
        send_key(robot_pkg::CODE_CAM);
        check_status(robot_pkg::CAM, robot_pkg::RIGHT);
        set_cam(1'b1, robot_pkg::DIR_LEFT, 2'd0);
        check_status(robot_pkg::CAM, robot_pkg::LEFT);
        set_cam(1'b1, robot_pkg::DIR_RIGHT, 2'd0);
        check_status(robot_pkg::CAM, robot_pkg::RIGHT);
        set_cam(1'b1, robot_pkg::DIR_NONE, 2'd0);
        check_status(robot_pkg::CAM, robot_pkg::STOP);
        for (int s = 0; s < 3; s++) begin
            set_cam(1'b1, robot_pkg::DIR_AHEAD, 2'(s));
            check_status(robot_pkg::CAM, robot_pkg::FORWARD);
            measure_period(robot_pkg::FORWARD, s);
        end
        set_cam(1'b0, robot_pkg::DIR_AHEAD, 2'd0);
        check_status(robot_pkg::CAM, robot_pkg::RIGHT);
        report_test("camera", err_before);
    endtask

    task automatic estop_test();
        int err_before;
        err_before = errors;
        send_key(robot_pkg::CODE_IR);
        check_status(robot_pkg::IR, robot_pkg::STOP);
        send_key(robot_pkg::CODE_FWD);
        check_status(robot_pkg::IR, robot_pkg::FORWARD);
        distance = robot_pkg::E_STOP_DIST;
        repeat (3) @(negedge CLOCK_50);
        check_status(robot_pkg::IR, robot_pkg::FORWARD);
        distance = 8'(20 + ($urandom % 236));
        repeat (3) @(negedge CLOCK_50);
        check_status(robot_pkg::IR, robot_pkg::FORWARD);
        distance = 8'($urandom % 20);
        send_key(robot_pkg::CODE_CAM);  // key in the same cycle as the obstacle.
        check_status(robot_pkg::IDLE, robot_pkg::STOP);
        measure_period(robot_pkg::STOP, gear_model);
        distance = 8'd200;
        report_test("emergency_stop", err_before);
    endtask

    initial begin
        void'($urandom(32'hcebe_5890));
        rst_n     = 1'b0;
        key_valid = 1'b0;
        key_code  = 8'h00;
        cam       = '{orange: 1'b0, dir: robot_pkg::DIR_NONE, speed: 2'd0};
        distance  = 8'd200;
        repeat (3) @(negedge CLOCK_50);
        rst_n = 1'b1;
        reset_state_test();
        mode_key_test();
        remote_cmd_test();
        gear_test();
        camera_test();
        estop_test();
        $display("summary: %0d checks passed, %0d errors", checks - errors, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: list.f
common/robot_pkg.sv
design/drive_mode_fsm.sv
design/pwm_timer.sv
motor/motor_drive.sv
design/robot_car_top.sv
verification/robot_car_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the robot car testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module robot_car_tb \
    -f list.f -Mdir obj_dir > sim.log 2>&1 &&
    ./obj_dir/Vrobot_car_tb >> sim.log 2>&1
cat sim.log
grep -q "^NO ERRORS$" sim.log && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}
